/* src/bridgePkg.sv */
// ----------------------------------------------------------
// Bus widths, AHB transfer codes and APB region map of the
// AHB-Lite to APB bridge.
// The three regions are contiguous and must not overlap.
// ----------------------------------------------------------
`default_nettype none

package bridgePkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int selWidth = 3;

	// htrans encodings.
	localparam logic [1:0] htransIdle = 2'b00;
	localparam logic [1:0] htransBusy = 2'b01;
	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq = 2'b11;

	// one region per Pselx bit.
	localparam logic [addrWidth-1:0] regionBase0 = 32'h8000_0000;
	localparam logic [addrWidth-1:0] regionBase1 = 32'h8400_0000;
	localparam logic [addrWidth-1:0] regionBase2 = 32'h8800_0000;
	localparam logic [addrWidth-1:0] regionSize = 32'h0400_0000;

	typedef enum logic [2:0] {
		idle = 3'b000,
		wWait = 3'b001,
		read = 3'b010,
		write = 3'b011,
		writeP = 3'b100,
		rEnable = 3'b101,
		wEnable = 3'b110,
		wEnableP = 3'b111
	} apbState_t;

endpackage

`default_nettype wire

/* src/ahbSlaveInterface.sv */
// ----------------------------------------------------------
// AHB-Lite slave front end of the bridge.
// Only NONSEQ and SEQ transfers inside the three APB regions
// raise valid; Hsize, Hprot and burst type are ignored.
// The address, data and direction history moves only while
// Hreadyin is high.
// ----------------------------------------------------------
`default_nettype none

module ahbSlaveInterface (
	input  logic Hclk,
	input  logic Hresetn,
	input  logic Hwrite,
	input  logic Hreadyin,
	input  logic [1:0] Htrans,
	input  logic [bridgePkg::addrWidth-1:0] Haddr,
	input  logic [bridgePkg::dataWidth-1:0] Hwdata,
	output logic valid,
	output logic Hwritereg,
	output logic [bridgePkg::addrWidth-1:0] Haddr1,
	output logic [bridgePkg::addrWidth-1:0] Haddr2,
	output logic [bridgePkg::dataWidth-1:0] Hwdata1,
	output logic [bridgePkg::dataWidth-1:0] Hwdata2,
	output logic [bridgePkg::selWidth-1:0] tempselx
);
	import bridgePkg::*;

	logic activeTrans;

	always_comb
	begin
		case (Htrans)
			htransNonseq, htransSeq:
				activeTrans = 1'b1;
			htransIdle, htransBusy:
				activeTrans = 1'b0;
			default:
				activeTrans = 1'b0;
		endcase
	end

	// region decode.
	always_comb
	begin
		tempselx = '0;
		if (Haddr >= regionBase0 && Haddr < regionBase0 + regionSize)
			tempselx[0] = 1'b1;
		if (Haddr >= regionBase1 && Haddr < regionBase1 + regionSize)
			tempselx[1] = 1'b1;
		if (Haddr >= regionBase2 && Haddr < regionBase2 + regionSize)
			tempselx[2] = 1'b1;
	end

	assign valid = Hreadyin && activeTrans && (tempselx != '0);

	// two accepted phases of history.
	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
		begin
			Haddr1 <= Haddr;
			Haddr2 <= Haddr1;
			Hwdata1 <= Hwdata;
			Hwdata2 <= Hwdata1;
		end
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hwritereg <= 1'b0;
		else if (Hreadyin)
			Hwritereg <= Hwrite;
	end

	assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(tempselx));
	// valid only inside the mapped window.
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		valid |-> (Haddr >= regionBase0) && (Haddr < regionBase2 + regionSize));

endmodule

`default_nettype wire

/* src/apbController.sv */
// ----------------------------------------------------------
// APB sequencer of the bridge, eight states.
// All APB outputs and Hreadyout are registered.
// Assumes Hreadyin is tied to Hreadyout (single slave) and
// that Pready is always high; Pslverr is not supported.
// Back-to-back writes queue at most one transfer behind the
// one on the APB.
// ----------------------------------------------------------
`default_nettype none

module apbController (
	input  logic Hclk,
	input  logic Hresetn,
	input  logic valid,
	input  logic Hwrite,
	input  logic Hwritereg,
	input  logic [bridgePkg::addrWidth-1:0] Haddr,
	input  logic [bridgePkg::addrWidth-1:0] Haddr1,
	input  logic [bridgePkg::addrWidth-1:0] Haddr2,
	input  logic [bridgePkg::dataWidth-1:0] Hwdata,
	input  logic [bridgePkg::dataWidth-1:0] Hwdata1,
	input  logic [bridgePkg::dataWidth-1:0] Hwdata2,
	input  logic [bridgePkg::selWidth-1:0] tempselx,
	output logic Pwrite,
	output logic Penable,
	output logic Hreadyout,
	output logic [bridgePkg::selWidth-1:0] Pselx,
	output logic [bridgePkg::addrWidth-1:0] Paddr,
	output logic [bridgePkg::dataWidth-1:0] Pwdata
);
	import bridgePkg::*;

	apbState_t state;
	apbState_t nextState;
	logic [selWidth-1:0] pendSelx;
	logic nextPwrite;
	logic nextPenable;
	logic nextHreadyout;
	logic [selWidth-1:0] nextPselx;
	logic [addrWidth-1:0] nextPaddr;
	logic [dataWidth-1:0] nextPwdata;

	always_comb
	begin
		case (state)
			idle, rEnable, wEnable:
			begin
				if (!valid)
					nextState = idle;
				else if (Hwrite)
					nextState = wWait;
				else
					nextState = read;
			end
			wWait:
				nextState = valid ? writeP : write;
			read:
				nextState = rEnable;
			write:
				nextState = valid ? wEnableP : wEnable;
			writeP:
				nextState = wEnableP;
			wEnableP:
			begin
				if (!Hwritereg)
					nextState = read;
				else if (valid)
					nextState = writeP;
				else
					nextState = write;
			end
			default:
				nextState = idle;
		endcase
	end

	always_comb
	begin
		nextPaddr = Paddr;
		nextPwdata = Pwdata;
		nextPwrite = Pwrite;
		nextPselx = '0;
		nextPenable = 1'b0;
		nextHreadyout = 1'b1;
		case (state)
			idle, rEnable, wEnable:
			begin
				// reads go straight to setup, writes wait for data.
				if (valid && !Hwrite)
				begin
					nextPaddr = Haddr;
					nextPwrite = 1'b0;
					nextPselx = tempselx;
					nextHreadyout = 1'b0;
				end
			end
			wWait:
			begin
				nextPaddr = Haddr1;
				nextPwdata = Hwdata;
				nextPwrite = 1'b1;
				nextPselx = pendSelx;
				nextHreadyout = 1'b0;
			end
			read:
			begin
				nextPselx = Pselx;
				nextPenable = 1'b1;
			end
			write, writeP:
			begin
				// the setup transfer has moved one stage down the history.
				nextPaddr = Haddr2;
				nextPwdata = Hwdata1;
				nextPselx = Pselx;
				nextPenable = 1'b1;
				// a queued read stays stalled until its own access.
				nextHreadyout = (state == write) || Hwritereg;
			end
			wEnableP:
			begin
				nextPaddr = Haddr1;
				nextPwdata = Hwdata;
				nextPwrite = Hwritereg;
				nextPselx = pendSelx;
				nextHreadyout = 1'b0;
			end
			default:
			begin
				nextPselx = '0;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= idle;
			pendSelx <= '0;
			Paddr <= '0;
			Pwdata <= '0;
			Pwrite <= 1'b0;
			Pselx <= '0;
			Penable <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// select of the last accepted address phase.
			if (valid)
				pendSelx <= tempselx;
			Paddr <= nextPaddr;
			Pwdata <= nextPwdata;
			Pwrite <= nextPwrite;
			Pselx <= nextPselx;
			Penable <= nextPenable;
			Hreadyout <= nextHreadyout;
		end
	end

	// access follows a setup to the same address.
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Pselx) != '0) && (Paddr == $past(Paddr)));
	assert property (@(posedge Hclk) disable iff (!Hresetn) Penable |=> !Penable);
	assert property (@(posedge Hclk) disable iff (!Hresetn) !$isunknown(state));
	// after a queued write, hwdata2 still holds the write just finished.
	assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state inside {write, writeP}) && ($past(state) == wEnableP)
		|-> Hwdata2 == $past(Pwdata));

endmodule

`default_nettype wire

/* src/ahbApbBridge.sv */
// ----------------------------------------------------------
// AHB-Lite to APB bridge top level.
// Hreadyin must be looped back from Hreadyout outside.
// No Hresp, no Pready and no Pslverr; Hrdata is Prdata
// without a register.
// ----------------------------------------------------------
`default_nettype none

module ahbApbBridge (
	input  logic Hclk,
	input  logic Hresetn,
	input  logic [1:0] Htrans,
	input  logic Hwrite,
	input  logic Hreadyin,
	input  logic [bridgePkg::addrWidth-1:0] Haddr,
	input  logic [bridgePkg::dataWidth-1:0] Hwdata,
	output logic Hreadyout,
	output logic [bridgePkg::dataWidth-1:0] Hrdata,
	output logic [bridgePkg::selWidth-1:0] Pselx,
	output logic Penable,
	output logic Pwrite,
	output logic [bridgePkg::addrWidth-1:0] Paddr,
	output logic [bridgePkg::dataWidth-1:0] Pwdata,
	input  logic [bridgePkg::dataWidth-1:0] Prdata
);
	import bridgePkg::*;

	logic valid;
	logic Hwritereg;
	logic [addrWidth-1:0] Haddr1;
	logic [addrWidth-1:0] Haddr2;
	logic [dataWidth-1:0] Hwdata1;
	logic [dataWidth-1:0] Hwdata2;
	logic [selWidth-1:0] tempselx;

	ahbSlaveInterface ahbIf_i (.Hclk, .Hresetn, .Hwrite, .Hreadyin, .Htrans, .Haddr,
		.Hwdata, .valid, .Hwritereg, .Haddr1, .Haddr2, .Hwdata1, .Hwdata2, .tempselx);

	apbController apbCtrl_i (.Hclk, .Hresetn, .valid, .Hwrite, .Hwritereg, .Haddr,
		.Haddr1, .Haddr2, .Hwdata, .Hwdata1, .Hwdata2, .tempselx, .Pwrite, .Penable,
		.Hreadyout, .Pselx, .Paddr, .Pwdata);

	// read data passes straight through.
	assign Hrdata = Prdata;

endmodule

`default_nettype wire

/* dv/apbPeripheralModel.sv */
// ----------------------------------------------------------
// Zero-wait APB memory with one bank per Pselx bit.
// Each bank has 16 words indexed by Paddr[5:2]; the other
// address bits are ignored. Bank b, word i powers up as
// 32'h5000_0000 + (b << 8) + i. Reads are combinational.
// ----------------------------------------------------------
`default_nettype none

module apbPeripheralModel (
	input  logic Hclk,
	input  logic [bridgePkg::selWidth-1:0] Pselx,
	input  logic Penable,
	input  logic Pwrite,
	input  logic [bridgePkg::addrWidth-1:0] Paddr,
	input  logic [bridgePkg::dataWidth-1:0] Pwdata,
	output logic [bridgePkg::dataWidth-1:0] Prdata
);
	timeunit 1ns;
	timeprecision 1ns;
	import bridgePkg::*;

	logic [dataWidth-1:0] mem [selWidth][16];

	initial
	begin
		for (int b = 0; b < selWidth; b++)
			for (int i = 0; i < 16; i++)
				mem[b][i] = 32'h5000_0000 + (b << 8) + i;
	end

	always_comb
	begin
		Prdata = '0;
		for (int b = 0; b < selWidth; b++)
			if (Pselx[b])
				Prdata = mem[b][Paddr[5:2]];
	end

	// write at the end of the access cycle.
	always @(posedge Hclk)
	begin
		for (int b = 0; b < selWidth; b++)
			if (Pselx[b] && Penable && Pwrite)
				mem[b][Paddr[5:2]] <= Pwdata;
	end

endmodule

`default_nettype wire

/* dv/bridgeTb.sv */
// ----------------------------------------------------------
// Testbench of the AHB-Lite to APB bridge.
// Transfers and expected read data come from
// dv/bridgeGolden.txt, read relative to the project root.
// The AHB master is pipelined and drives on the falling edge;
// Hreadyin is looped back from Hreadyout.
// ----------------------------------------------------------
`default_nettype none

module bridgeTb;
	timeunit 1ns;
	timeprecision 1ns;
	import bridgePkg::*;

	localparam int stallLimit = 16;
	localparam int drainLimit = 10;

	logic Hclk;
	logic Hresetn;
	logic [1:0] Htrans;
	logic Hwrite;
	logic Hreadyin;
	logic [addrWidth-1:0] Haddr;
	logic [dataWidth-1:0] Hwdata;
	logic Hreadyout;
	logic [dataWidth-1:0] Hrdata;
	logic [selWidth-1:0] Pselx;
	logic Penable;
	logic Pwrite;
	logic [addrWidth-1:0] Paddr;
	logic [dataWidth-1:0] Pwdata;
	logic [dataWidth-1:0] Prdata;

	// golden lines.
	int kindQ[$];
	logic [addrWidth-1:0] addrQ[$];
	logic [dataWidth-1:0] wdataQ[$];
	logic [dataWidth-1:0] rdataQ[$];
	logic nextQ[$];

	// expected APB accesses, in order.
	logic [addrWidth-1:0] expAddr[$];
	logic expWrite[$];
	logic [selWidth-1:0] expSel[$];
	logic [dataWidth-1:0] expData[$];

	int mismatchCount = 0;
	int failureCount = 0;
	int completedCount = 0;
	int transferCount = 0;

	assign Hreadyin = Hreadyout;

	ahbApbBridge dut_i (.Hclk, .Hresetn, .Htrans, .Hwrite, .Hreadyin, .Haddr, .Hwdata,
		.Hreadyout, .Hrdata, .Pselx, .Penable, .Pwrite, .Paddr, .Pwdata, .Prdata);

	apbPeripheralModel apbMem_i (.Hclk, .Pselx, .Penable, .Pwrite, .Paddr, .Pwdata,
		.Prdata);

	initial
		Hclk = 1'b0;
	always #50 Hclk = ~Hclk;

	function automatic logic [selWidth-1:0] decodeRegion(logic [addrWidth-1:0] a);
		logic [selWidth-1:0] sel;
		sel = '0;
		if (a >= regionBase0 && a - regionBase0 < regionSize)
			sel[0] = 1'b1;
		if (a >= regionBase1 && a - regionBase1 < regionSize)
			sel[1] = 1'b1;
		if (a >= regionBase2 && a - regionBase2 < regionSize)
			sel[2] = 1'b1;
		return sel;
	endfunction

	task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		mismatchCount++;
	endtask

	task automatic checkResetOutputs();
		if (Pselx !== '0)
			reportMismatch("Pselx", Pselx, '0);
		if (Penable !== 1'b0)
			reportMismatch("Penable", Penable, 1'b0);
		if (Pwrite !== 1'b0)
			reportMismatch("Pwrite", Pwrite, 1'b0);
		if (Hreadyout !== 1'b0)
			reportMismatch("Hreadyout", Hreadyout, 1'b0);
	endtask

	task automatic finishRun();
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	task automatic loadGolden();
		int fd;
		int k;
		logic [31:0] a;
		logic [31:0] w;
		logic [31:0] r;
		int n;
		string line;
		fd = $fopen("dv/bridgeGolden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the golden file dv/bridgeGolden.txt");
			failureCount++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if ($sscanf(line, "%h %h %h %h %h", k, a, w, r, n) == 5)
			begin
				kindQ.push_back(k);
				addrQ.push_back(a);
				wdataQ.push_back(w);
				rdataQ.push_back(r);
				nextQ.push_back(n != 0);
				if (k < 2)
					transferCount++;
				if (k < 2 && decodeRegion(a) != '0)
				begin
					expAddr.push_back(a);
					expWrite.push_back(k == 1);
					expSel.push_back(decodeRegion(a));
					expData.push_back(w);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic driveAddress(int idx);
		if (idx < 0)
		begin
			Htrans = htransIdle;
			Haddr = '0;
			Hwrite = 1'b0;
		end
		else
		begin
			case (kindQ[idx])
				0, 1:
					Htrans = (idx > 0 && nextQ[idx-1]) ? htransSeq : htransNonseq;
				2:
					Htrans = htransIdle;
				default:
					Htrans = htransBusy;
			endcase
			Haddr = addrQ[idx];
			Hwrite = (kindQ[idx] == 1);
		end
	endtask

	// an isolated filtered transfer leaves the bridge idle.
	task automatic checkFilteredPhase(int idx, logic rdy);
		if (kindQ[idx] >= 2 || decodeRegion(addrQ[idx]) == '0)
			if (idx == 0 || !nextQ[idx-1])
			begin
				if (rdy !== 1'b1)
					reportMismatch("Hreadyout", rdy, 1'b1);
				if (Pselx !== '0)
					reportMismatch("Pselx", Pselx, '0);
			end
	endtask

	task automatic completeDataPhase(int idx);
		if (kindQ[idx] < 2)
			completedCount++;
		if (kindQ[idx] == 0 && decodeRegion(addrQ[idx]) != '0)
			if (Hrdata !== rdataQ[idx])
				reportMismatch("Hrdata", Hrdata, rdataQ[idx]);
	endtask

	// APB access monitor.
	always @(negedge Hclk)
	begin
		if (Hresetn && Penable)
		begin
			if (expAddr.size() == 0)
			begin
				$display("Unexpected APB access at %0t to address %h", $time, Paddr);
				failureCount++;
			end
			else
			begin
				if (Paddr !== expAddr[0])
					reportMismatch("Paddr", Paddr, expAddr[0]);
				if (Pwrite !== expWrite[0])
					reportMismatch("Pwrite", Pwrite, expWrite[0]);
				if (Pselx !== expSel[0])
					reportMismatch("Pselx", Pselx, expSel[0]);
				if (expWrite[0] && Pwdata !== expData[0])
					reportMismatch("Pwdata", Pwdata, expData[0]);
				void'(expAddr.pop_front());
				void'(expWrite.pop_front());
				void'(expSel.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	initial
	begin
		int addrIdx;
		int dataIdx;
		int nextLine;
		int stall;
		int drain;
		logic prevReady;
		logic ready;
		logic gapPending;
		logic timedOut;
		Hresetn = 1'b0;
		Htrans = htransIdle;
		Hwrite = 1'b0;
		Haddr = '0;
		Hwdata = '0;
		loadGolden();
		repeat (2)
		begin
			@(negedge Hclk);
			checkResetOutputs();
		end
		Hresetn = 1'b1;
		checkResetOutputs();
		addrIdx = -1;
		dataIdx = -1;
		nextLine = 0;
		stall = 0;
		prevReady = 1'b1;
		gapPending = 1'b0;
		timedOut = 1'b0;
		while ((nextLine < kindQ.size() || addrIdx >= 0 || dataIdx >= 0) && !timedOut)
		begin
			@(negedge Hclk);
			ready = Hreadyout;
			if (prevReady)
			begin
				dataIdx = addrIdx;
				if (gapPending || nextLine >= kindQ.size())
				begin
					addrIdx = -1;
					gapPending = 1'b0;
				end
				else
				begin
					addrIdx = nextLine;
					gapPending = !nextQ[nextLine];
					nextLine++;
				end
				driveAddress(addrIdx);
				Hwdata = (dataIdx >= 0 && kindQ[dataIdx] == 1) ? wdataQ[dataIdx] : '0;
				if (dataIdx >= 0)
					checkFilteredPhase(dataIdx, ready);
			end
			if (ready && dataIdx >= 0)
			begin
				completeDataPhase(dataIdx);
				dataIdx = -1;
			end
			stall = ready ? 0 : stall + 1;
			if (stall > stallLimit)
			begin
				$display("Timeout: Hreadyout stayed low for %0d cycles", stall);
				failureCount++;
				timedOut = 1'b1;
			end
			prevReady = ready;
		end
		drain = 0;
		while (expAddr.size() != 0 && drain < drainLimit)
		begin
			@(negedge Hclk);
			drain++;
		end
		if (expAddr.size() != 0)
		begin
			$display("Timeout: %0d expected APB accesses never occurred", expAddr.size());
			failureCount++;
		end
		if (completedCount != transferCount)
		begin
			$display("Completed %0d AHB transfers but %0d were issued", completedCount,
				transferCount);
			failureCount++;
		end
		finishRun();
	end

endmodule

`default_nettype wire

/* sources.f */
src/bridgePkg.sv
src/ahbSlaveInterface.sv
src/apbController.sv
src/ahbApbBridge.sv
dv/apbPeripheralModel.sv
dv/bridgeTb.sv

/* Bender.yml */
package:
  name: ahb_apb_bridge

sources:
  - files:
      - src/bridgePkg.sv
      - src/ahbSlaveInterface.sv
      - src/apbController.sv
      - src/ahbApbBridge.sv
  - target: test
    files:
      - dv/apbPeripheralModel.sv
      - dv/bridgeTb.sv

/* dv/bridgeGolden.txt */
// kind(0 read, 1 write, 2 idle, 3 busy) address wdata expected_rdata next
// next is 1 when the following transfer starts with no idle cycle.
// isolated reads of the power-up contents.
0 80000000 00000000 50000000 0
0 84000014 00000000 50000105 0
0 88000038 00000000 5000020e 0
// isolated writes and their read-backs.
1 80000008 11112222 00000000 0
1 84000004 33334444 00000000 0
1 8800003c 55556666 00000000 0
0 80000008 00000000 11112222 0
0 84000004 00000000 33334444 0
0 8800003c 00000000 55556666 0
// back-to-back writes then back-to-back reads.
1 80000010 a0a0a001 00000000 1
1 84000010 a0a0a002 00000000 1
1 88000010 a0a0a003 00000000 1
1 80000014 a0a0a004 00000000 0
0 80000010 00000000 a0a0a001 1
0 84000010 00000000 a0a0a002 1
0 88000010 00000000 a0a0a003 1
0 80000014 00000000 a0a0a004 0
// write then read, read then write.
1 84000020 cafe0001 00000000 1
0 84000020 00000000 cafe0001 0
0 88000024 00000000 50000209 1
1 88000024 beef0002 00000000 0
0 88000024 00000000 beef0002 0
1 8000002c 12345678 00000000 1
0 84000030 00000000 5000010c 0
// filtered transfers.
2 80000000 00000000 00000000 0
3 84000000 00000000 00000000 0
0 90000000 00000000 00000000 0
1 7ffffffc deadbeef 00000000 0
0 8c000000 00000000 00000000 0
0 80000000 00000000 50000000 0
// write, idle, read with no gaps.
1 80000030 77770001 00000000 1
2 00000000 00000000 00000000 1
0 80000030 00000000 77770001 0
3 88000000 00000000 00000000 1
1 88000000 99990003 00000000 1
0 88000000 00000000 99990003 0
